/* hdl/sift_pkg.sv */
package sift_pkg;

    // frame geometry
    localparam int img_width  = 64;
    localparam int img_height = 64;
    localparam int img_pixels = img_width * img_height;  // bytes per frame

    localparam int bit_depth  = 8;                       // greyscale
    localparam int addr_bits  = $clog2(img_pixels);

    // one pixel, also one uart byte
    typedef logic [bit_depth-1:0] pixel_t;

    // linear address into the frame
    typedef logic [addr_bits-1:0] pixel_addr_t;

    // received byte, valid high for a single cycle
    typedef struct packed {
        logic   valid;
        pixel_t data;
    } rx_beat_t;

    // sender fsm
    typedef enum logic [2:0] {
        st_idle,
        st_fetch,   // read request plus read latency
        st_start,
        st_data,
        st_stop
    } sender_state_t;

endpackage

/* hdl/uart_rx.sv */
`timescale 1ns/10ps

module uart_rx import sift_pkg::*; #(
    parameter int clks_per_baud = 50
) (
    input  logic     clk_100mhz,
    input  logic     sys_rst,
    input  logic     rxd_i,
    output rx_beat_t beat_o
);

    localparam int cnt_w = $clog2(clks_per_baud + 1);

    logic [1:0]       rxd_sync;  // two flop synchronizer
    logic             rxd_prev;
    logic             busy;
    logic [3:0]       bit_idx;   // 0 start, 1..8 data, 9 stop
    logic [cnt_w-1:0] baud_cnt;
    pixel_t           rx_byte;

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            rxd_sync     <= 2'b11;  // line idles high
            rxd_prev     <= 1'b1;
            busy         <= 1'b0;
            bit_idx      <= '0;
            baud_cnt     <= '0;
            beat_o.valid <= 1'b0;
        end else begin
            rxd_sync     <= {rxd_sync[0], rxd_i};
            rxd_prev     <= rxd_sync[1];
            beat_o.valid <= 1'b0;
            if (!busy) begin
                if (rxd_prev && !rxd_sync[1]) begin  // falling start edge
                    busy     <= 1'b1;
                    bit_idx  <= '0;
                    baud_cnt <= cnt_w'(clks_per_baud / 2 - 1);  // aim mid-bit
                end
            end else if (baud_cnt != '0) begin
                baud_cnt <= baud_cnt - 1'b1;
            end else begin
                baud_cnt <= cnt_w'(clks_per_baud - 1);
                bit_idx  <= bit_idx + 1'b1;
                if (bit_idx == 4'd0) begin
                    busy <= ~rxd_sync[1];  // glitch, not a real start bit
                end else if (bit_idx == 4'd9) begin
                    busy <= 1'b0;
                    if (rxd_sync[1]) begin  // framing error drops the byte
                        beat_o.valid <= 1'b1;
                        beat_o.data  <= rx_byte;
                    end
                end else begin
                    rx_byte <= {rxd_sync[1], rx_byte[bit_depth-1:1]};  // lsb first
                end
            end
        end
    end

    // the frame buffer writes once per beat, so a beat must never stretch
    assert property (@(posedge clk_100mhz) disable iff (sys_rst)
        beat_o.valid |=> !beat_o.valid);

endmodule

/* hdl/frame_buffer.sv */
`timescale 1ns/10ps

module frame_buffer import sift_pkg::*; (
    input  logic        clk_100mhz,
    input  logic        sys_rst,
    input  rx_beat_t    beat_i,
    input  logic        rd_en_i,
    input  pixel_addr_t rd_addr_i,
    output pixel_t      rd_data_o,
    output logic        frame_full_o
);

    pixel_t      mem [img_pixels];  // block ram
    pixel_addr_t wr_addr;
    logic        wr_en;

    assign wr_en = beat_i.valid && !frame_full_o;  // extra bytes are dropped

    // write counter and full flag
    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            wr_addr      <= '0;
            frame_full_o <= 1'b0;
        end else if (wr_en) begin
            wr_addr <= wr_addr + 1'b1;  // wraps to 0 after the last pixel
            if (wr_addr == pixel_addr_t'(img_pixels - 1)) begin
                frame_full_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (wr_en) begin
            mem[wr_addr] <= beat_i.data;
        end
    end

    // registered read, one cycle latency
    always_ff @(posedge clk_100mhz) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

    // the sender may only read back a complete frame
    assert property (@(posedge clk_100mhz) disable iff (sys_rst)
        rd_en_i |-> frame_full_o);

endmodule

/* hdl/button_debouncer.sv */
`timescale 1ns/10ps

module button_debouncer #(
    parameter int debounce_cycles = 1_000_000
) (
    input  logic clk_100mhz,
    input  logic sys_rst,
    input  logic btn_i,
    output logic press_o
);

    localparam int cnt_w = $clog2(debounce_cycles + 1);

    logic [1:0]       btn_sync;
    logic             clean;       // debounced level
    logic [cnt_w-1:0] stable_cnt;  // cycles the raw level has differed from clean

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            btn_sync   <= '0;
            clean      <= 1'b0;
            stable_cnt <= '0;
            press_o    <= 1'b0;
        end else begin
            btn_sync <= {btn_sync[0], btn_i};
            press_o  <= 1'b0;
            if (btn_sync[1] == clean) begin
                stable_cnt <= '0;  // bounce back, start over
            end else if (stable_cnt == cnt_w'(debounce_cycles - 1)) begin
                clean      <= btn_sync[1];
                stable_cnt <= '0;
                press_o    <= btn_sync[1];  // pulse on rising clean level only
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

endmodule

/* hdl/image_sender.sv */
`timescale 1ns/10ps

module image_sender import sift_pkg::*; #(
    parameter int clks_per_baud = 50
) (
    input  logic        clk_100mhz,
    input  logic        sys_rst,
    input  logic        press_i,
    input  logic        frame_full_i,
    output logic        rd_en_o,
    output pixel_addr_t rd_addr_o,
    input  pixel_t      rd_data_i,
    output logic        txd_o,
    output logic        sending_o
);

    localparam int cnt_w = $clog2(clks_per_baud + 1);

    sender_state_t    state;
    pixel_addr_t      addr;
    logic [cnt_w-1:0] baud_cnt;
    logic [2:0]       bit_idx;
    pixel_t           tx_byte;   // shifted out lsb first

    assign rd_en_o   = (state == st_fetch);
    assign rd_addr_o = addr;

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            state     <= st_idle;
            addr      <= '0;
            baud_cnt  <= '0;
            bit_idx   <= '0;
            txd_o     <= 1'b1;
            sending_o <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    txd_o <= 1'b1;
                    if (press_i && frame_full_i) begin
                        state     <= st_fetch;
                        sending_o <= 1'b1;
                        baud_cnt  <= cnt_w'(1);  // two cycles in fetch
                    end
                end
                st_fetch: begin
                    if (baud_cnt != '0) begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end else begin
                        // read data valid now
                        tx_byte  <= rd_data_i;
                        txd_o    <= 1'b0;  // start bit
                        baud_cnt <= cnt_w'(clks_per_baud - 1);
                        state    <= st_start;
                    end
                end
                st_start: begin
                    if (baud_cnt != '0) begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end else begin
                        txd_o    <= tx_byte[0];
                        tx_byte  <= tx_byte >> 1;
                        bit_idx  <= '0;
                        baud_cnt <= cnt_w'(clks_per_baud - 1);
                        state    <= st_data;
                    end
                end
                st_data: begin
                    if (baud_cnt != '0) begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end else begin
                        baud_cnt <= cnt_w'(clks_per_baud - 1);
                        if (bit_idx == 3'd7) begin
                            txd_o <= 1'b1;  // stop bit
                            state <= st_stop;
                        end else begin
                            txd_o   <= tx_byte[0];
                            tx_byte <= tx_byte >> 1;
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                st_stop: begin
                    if (baud_cnt != '0) begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end else begin
                        addr <= addr + 1'b1;  // wraps to 0 after the last pixel
                        if (addr == pixel_addr_t'(img_pixels - 1)) begin
                            state     <= st_idle;
                            sending_o <= 1'b0;
                        end else begin
                            state    <= st_fetch;
                            baud_cnt <= cnt_w'(1);
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // line must rest high between frames
    assert property (@(posedge clk_100mhz) disable iff (sys_rst)
        (state == st_idle) |-> txd_o);

endmodule

/* hdl/image_loopback_top.sv */
`timescale 1ns/10ps

module image_loopback_top import sift_pkg::*; #(
    parameter int clks_per_baud   = 50,
    parameter int debounce_cycles = 1_000_000
) (
    input  logic clk_100mhz,
    input  logic sys_rst,
    input  logic uart_rxd_i,
    input  logic btn_send_i,
    output logic uart_txd_o,
    output logic image_received_o,
    output logic sending_o
);

    rx_beat_t    rx_beat;
    logic        frame_full;
    logic        send_press;
    logic        rd_en;
    pixel_addr_t rd_addr;
    pixel_t      rd_data;

    assign image_received_o = frame_full;

    // producer
    uart_rx #(.clks_per_baud(clks_per_baud)) urx (
        .clk_100mhz (clk_100mhz),
        .sys_rst    (sys_rst),
        .rxd_i      (uart_rxd_i),
        .beat_o     (rx_beat)
    );

    frame_buffer fbuf (
        .clk_100mhz   (clk_100mhz),
        .sys_rst      (sys_rst),
        .beat_i       (rx_beat),
        .rd_en_i      (rd_en),
        .rd_addr_i    (rd_addr),
        .rd_data_o    (rd_data),
        .frame_full_o (frame_full)
    );

    button_debouncer #(.debounce_cycles(debounce_cycles)) send_db (
        .clk_100mhz (clk_100mhz),
        .sys_rst    (sys_rst),
        .btn_i      (btn_send_i),
        .press_o    (send_press)
    );

    // consumer
    image_sender #(.clks_per_baud(clks_per_baud)) utx (
        .clk_100mhz   (clk_100mhz),
        .sys_rst      (sys_rst),
        .press_i      (send_press),
        .frame_full_i (frame_full),
        .rd_en_o      (rd_en),
        .rd_addr_o    (rd_addr),
        .rd_data_i    (rd_data),
        .txd_o        (uart_txd_o),
        .sending_o    (sending_o)
    );

endmodule

/* verification/tb_image_loopback.sv */
`timescale 1ns/10ps

module tb_image_loopback import sift_pkg::*; ();

    localparam int bit_cycles     = 4;   // clks_per_baud of the dut
    localparam int db_cycles      = 8;
    localparam int reset_cycles   = 5;
    localparam int seed           = 60825;
    localparam int press_hold     = db_cycles + 6;  // long enough to pass the debouncer
    localparam int tx_byte_cycles = 10 * bit_cycles + 2;  // 8N1 plus two fetch cycles
    // about two frames of line time plus margin
    localparam int timeout_cycles = 450_000;

    logic   clk_100mhz = 1'b0;
    logic   sys_rst;
    logic   uart_rxd_i;
    logic   btn_send_i;
    logic   uart_txd_o;
    logic   image_received_o;
    logic   sending_o;

    pixel_t expected [img_pixels];
    int     error_count = 0;
    int     rx_count    = 0;   // bytes decoded from uart_txd_o
    int     send_starts = 0;
    int     cycle_count = 0;
    int     wait_cycles;
    logic   sending_prev = 1'b0;

    image_loopback_top #(.clks_per_baud(bit_cycles), .debounce_cycles(db_cycles)) dut0 (
        .clk_100mhz       (clk_100mhz),
        .sys_rst          (sys_rst),
        .uart_rxd_i       (uart_rxd_i),
        .btn_send_i       (btn_send_i),
        .uart_txd_o       (uart_txd_o),
        .image_received_o (image_received_o),
        .sending_o        (sending_o)
    );

    always #5 clk_100mhz = ~clk_100mhz;

    always @(posedge clk_100mhz) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("Something failed");
            $finish;
        end
    end

    assert property (@(posedge clk_100mhz) $fell(sys_rst) |->
        (uart_txd_o && !sending_o && !image_received_o))
        else begin
            error_count++;
            $display("outputs were not at their reset values when reset was released");
        end

    assert property (@(posedge clk_100mhz) disable iff (sys_rst) !sending_o |-> uart_txd_o)
        else begin
            error_count++;
            $display("MISMATCH uart_txd_o while idle: expected 1, got %h",
                $sampled(uart_txd_o));
        end

    assert property (@(posedge clk_100mhz) disable iff (sys_rst)
        !image_received_o |-> !sending_o)
        else begin
            error_count++;
            $display("MISMATCH sending_o before frame full: expected 0, got %h",
                $sampled(sending_o));
        end

    // once received, the frame stays received until reset
    assert property (@(posedge clk_100mhz) disable iff (sys_rst)
        image_received_o |=> image_received_o)
        else begin
            error_count++;
            $display("MISMATCH image_received_o: expected 1, got %h",
                $sampled(image_received_o));
        end

    always @(negedge clk_100mhz) begin
        if (sending_o === 1'b1 && !sending_prev) send_starts++;
        sending_prev <= (sending_o === 1'b1);
    end

    // sender leaves st_idle, each byte starts on a falling line
    initial begin : line_decoder
        pixel_t byte_val;
        forever begin
            @(negedge clk_100mhz);
            if (!sys_rst && uart_txd_o === 1'b0) begin
                repeat (bit_cycles / 2) @(negedge clk_100mhz);  // mid start bit
                assert (uart_txd_o === 1'b0) else begin
                    error_count++;
                    $display("MISMATCH uart_txd_o start bit of byte %0d: expected 0, got %h",
                        rx_count, uart_txd_o);
                end
                for (int b = 0; b < bit_depth; b++) begin
                    repeat (bit_cycles) @(negedge clk_100mhz);
                    byte_val[b] = uart_txd_o;  // lsb first
                end
                repeat (bit_cycles) @(negedge clk_100mhz);
                assert (uart_txd_o === 1'b1) else begin
                    error_count++;
                    $display("MISMATCH uart_txd_o stop bit of byte %0d: expected 1, got %h",
                        rx_count, uart_txd_o);
                end
                assert (rx_count < img_pixels) else begin
                    error_count++;
                    $display("more bytes came out than the frame holds");
                end
                if (rx_count < img_pixels) begin
                    assert (byte_val === expected[rx_count]) else begin
                        error_count++;
                        $display("MISMATCH uart_txd_o byte %0d: expected %02h, got %02h",
                            rx_count, expected[rx_count], byte_val);
                    end
                end
                rx_count++;
            end
        end
    end

    task automatic drive_bit(input logic v);
        @(posedge clk_100mhz);
        #1 uart_rxd_i = v;
        repeat (bit_cycles - 1) @(posedge clk_100mhz);
    endtask

    task automatic uart_send(input pixel_t b);
        drive_bit(1'b0);
        for (int i = 0; i < bit_depth; i++) drive_bit(b[i]);
        drive_bit(1'b1);
    endtask

    task automatic press_button(input int hold);
        @(posedge clk_100mhz);
        #1 btn_send_i = 1'b1;
        repeat (hold) @(posedge clk_100mhz);
        #1 btn_send_i = 1'b0;
        repeat (hold) @(posedge clk_100mhz);
    endtask

    initial begin
        void'($urandom(seed));
        sys_rst    = 1'b1;
        uart_rxd_i = 1'b1;
        btn_send_i = 1'b0;
        for (int i = 0; i < img_pixels; i++) expected[i] = pixel_t'($urandom);
        repeat (reset_cycles) @(posedge clk_100mhz);
        #1 sys_rst = 1'b0;

        for (int i = 0; i < img_pixels / 2; i++) uart_send(expected[i]);
        press_button(press_hold);  // frame only half full
        repeat (20) @(posedge clk_100mhz);
        assert (!sending_o && send_starts == 0 && rx_count == 0) else begin
            error_count++;
            $display("a press on a half-full frame started a transmission");
        end

        for (int i = img_pixels / 2; i < img_pixels; i++) begin
            uart_send(expected[i]);
            #1;  // stop bit still on the line
            assert (!image_received_o) else begin
                error_count++;
                $display("MISMATCH image_received_o after byte %0d: expected 0, got %h",
                    i, image_received_o);
            end
        end
        wait_cycles = 0;
        while (image_received_o !== 1'b1 && wait_cycles < 4 * bit_cycles) begin
            @(negedge clk_100mhz);
            wait_cycles++;
        end
        assert (image_received_o === 1'b1) else begin
            error_count++;
            $display("image_received_o did not rise after the last pixel");
        end

        for (int i = 0; i < 3; i++) uart_send(~expected[i]);  // dropped by the buffer
        repeat (10) @(posedge clk_100mhz);

        press_button(press_hold);
        assert (sending_o === 1'b1 && send_starts == 1) else begin
            error_count++;
            $display("a clean press on a full frame did not start sending");
        end
        repeat (500) @(posedge clk_100mhz);
        press_button(press_hold);  // ignored while busy

        wait_cycles = 0;
        while (sending_o !== 1'b0 && wait_cycles < img_pixels * tx_byte_cycles + 100) begin
            @(negedge clk_100mhz);
            wait_cycles++;
        end
        assert (sending_o === 1'b0) else begin
            error_count++;
            $display("sending_o did not fall after the frame");
        end
        assert (rx_count == img_pixels) else begin
            error_count++;
            $display("MISMATCH byte count at end of send: expected %0h, got %0h",
                img_pixels, rx_count);
        end

        // bounce, every pulse shorter than the debounce time
        for (int k = 0; k < 5; k++) begin
            @(posedge clk_100mhz);
            #1 btn_send_i = 1'b1;
            repeat (4) @(posedge clk_100mhz);
            #1 btn_send_i = 1'b0;
            repeat (3) @(posedge clk_100mhz);
        end
        repeat (40) @(posedge clk_100mhz);
        assert (!sending_o && send_starts == 1 && rx_count == img_pixels) else begin
            error_count++;
            $display("a bouncing press or a press while busy started another transmission");
        end

        $display("errors: %0d, bytes checked: %0d, send starts: %0d",
            error_count, rx_count, send_starts);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* files.f */
hdl/sift_pkg.sv
hdl/uart_rx.sv
hdl/frame_buffer.sv
hdl/button_debouncer.sv
hdl/image_sender.sv
hdl/image_loopback_top.sv
verification/tb_image_loopback.sv

/* Bender.yml */
package:
  name: image_loopback

sources:
  # package first, then rtl in compile order
  - hdl/sift_pkg.sv
  - hdl/uart_rx.sv
  - hdl/frame_buffer.sv
  - hdl/button_debouncer.sv
  - hdl/image_sender.sv
  - hdl/image_loopback_top.sv

  # testbench
  - target: test
    files:
      - verification/tb_image_loopback.sv
